//--- Makefile
VERILATOR ?= verilator
TOP := tb_pipeline_core
FILELIST := sources.f
BUILD_DIR := obj_dir
LOG := sim.log
VFLAGS := --timing --assert --timescale 1ns/1ps
PASS_TEXT := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define CORE_XLEN 32

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

// base opcodes of the supported RV32I subset
`define CORE_OP_OP 7'b0110011
`define CORE_OP_OP_IMM 7'b0010011
`define CORE_OP_LUI 7'b0110111
`define CORE_OP_LOAD 7'b0000011
`define CORE_OP_STORE 7'b0100011
`define CORE_OP_BRANCH 7'b1100011
`define CORE_OP_JAL 7'b1101111

`endif

//--- common/core_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // add is zero so that a cleared payload computes nothing harmful
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8,
        ALU_PASS_B = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB = 2'd2
    } fwd_sel_e;

    // decode to execute
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch;
        logic branch_ne;
        logic jump;
        logic alu_src;
        alu_op_e alu_op;
        result_src_e result_src;
        word_t rd1;
        word_t rd2;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t imm;
        word_t pc;
        word_t pc_plus4;
    } dec_payload_t;

    // execute to memory
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        result_src_e result_src;
        word_t alu_result;
        word_t write_data;
        reg_idx_t rd;
        word_t pc_plus4;
    } exec_payload_t;

    // memory to writeback
    typedef struct packed {
        logic reg_write;
        result_src_e result_src;
        word_t alu_result;
        word_t read_data;
        reg_idx_t rd;
        word_t pc_plus4;
    } wb_payload_t;

endpackage

`default_nettype wire

//--- core/exec.sv
`default_nettype none

module exec (
    input wire core_pkg::dec_payload_t payload,
    input wire core_pkg::fwd_sel_e fwd_a,
    input wire core_pkg::fwd_sel_e fwd_b,
    input wire core_pkg::word_t alu_result_m,
    input wire core_pkg::word_t result_w,
    output core_pkg::exec_payload_t payload_out,
    output logic pc_src,
    output core_pkg::word_t pc_target
);

    core_pkg::word_t src_a;
    core_pkg::word_t src_b_reg;
    core_pkg::word_t src_b;
    core_pkg::word_t alu_out;
    logic equal;

    function automatic core_pkg::word_t fwd_mux(
        input core_pkg::fwd_sel_e sel,
        input core_pkg::word_t rf_val,
        input core_pkg::word_t mem_val,
        input core_pkg::word_t wb_val
    );
        core_pkg::word_t val;
        case (sel)
            core_pkg::FWD_MEM: val = mem_val;
            core_pkg::FWD_WB: val = wb_val;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign src_a = fwd_mux(fwd_a, payload.rd1, alu_result_m, result_w);
    assign src_b_reg = fwd_mux(fwd_b, payload.rd2, alu_result_m, result_w);
    assign src_b = payload.alu_src ? payload.imm : src_b_reg;

    always_comb begin
        case (payload.alu_op)
            core_pkg::ALU_SUB: alu_out = src_a - src_b;
            core_pkg::ALU_AND: alu_out = src_a & src_b;
            core_pkg::ALU_OR: alu_out = src_a | src_b;
            core_pkg::ALU_XOR: alu_out = src_a ^ src_b;
            core_pkg::ALU_SLT: alu_out = {31'd0, $signed(src_a) < $signed(src_b)};
            core_pkg::ALU_SLL: alu_out = src_a << src_b[4:0];
            core_pkg::ALU_SRL: alu_out = src_a >> src_b[4:0];
            core_pkg::ALU_SRA: alu_out = core_pkg::word_t'($signed(src_a) >>> src_b[4:0]);
            core_pkg::ALU_PASS_B: alu_out = src_b;
            default: alu_out = src_a + src_b;
        endcase
    end

    // branch compare uses the forwarded register operands
    assign equal = (src_a == src_b_reg);
    assign pc_target = payload.pc + payload.imm;
    assign pc_src = payload.jump || (payload.branch && (payload.branch_ne ? !equal : equal));

    assign payload_out.reg_write = payload.reg_write;
    assign payload_out.mem_read = payload.mem_read;
    assign payload_out.mem_write = payload.mem_write;
    assign payload_out.result_src = payload.result_src;
    assign payload_out.alu_result = alu_out;
    assign payload_out.write_data = src_b_reg;
    assign payload_out.rd = payload.rd;
    assign payload_out.pc_plus4 = payload.pc_plus4;

endmodule

`default_nettype wire

//--- core/instr_decode.sv
`default_nettype none

`include "core_defs.svh"

module instr_decode (
    input wire clk,
    input wire rst,
    input wire core_pkg::word_t instr_d,
    input wire core_pkg::word_t pc_d,
    input wire core_pkg::reg_idx_t rd_w,
    input wire core_pkg::word_t result_w,
    input wire reg_write_w,
    output core_pkg::dec_payload_t payload
);

    // x0 has no storage
    core_pkg::word_t regs [1:31];

    logic [6:0] opcode;
    logic [2:0] funct3;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::word_t rd1;
    core_pkg::word_t rd2;
    logic we;
    logic known;
    logic use_rs1;
    logic use_rs2;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_s;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_u;
    core_pkg::word_t imm_j;

    assign opcode = instr_d[6:0];
    assign funct3 = instr_d[14:12];
    assign rs1 = instr_d[19:15];
    assign rs2 = instr_d[24:20];

    assign we = reg_write_w && (rd_w != 5'd0) && !rst;

    always_ff @(posedge clk) begin
        if (we) begin
            regs[rd_w] <= result_w;
        end
    end

    // write-first so a same-cycle writeback is seen here
    assign rd1 = (rs1 == 5'd0) ? '0 : (we && rd_w == rs1) ? result_w : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : (we && rd_w == rs2) ? result_w : regs[rs2];

    assign imm_i = {{20{instr_d[31]}}, instr_d[31:20]};
    assign imm_s = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
    assign imm_b = {{19{instr_d[31]}}, instr_d[31], instr_d[7], instr_d[30:25],
                    instr_d[11:8], 1'b0};
    assign imm_u = {instr_d[31:12], 12'd0};
    assign imm_j = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12], instr_d[20],
                    instr_d[30:21], 1'b0};

    // alt selects sub and sra
    function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        core_pkg::alu_op_e op;
        case (f3)
            3'b000: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001: op = core_pkg::ALU_SLL;
            3'b010: op = core_pkg::ALU_SLT;
            3'b100: op = core_pkg::ALU_XOR;
            3'b101: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: op = core_pkg::ALU_OR;
            3'b111: op = core_pkg::ALU_AND;
            default: op = core_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        payload = '0;
        known = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (opcode)
            `CORE_OP_OP: begin
                payload.reg_write = 1'b1;
                payload.alu_op = alu_decode(funct3, instr_d[30]);
                use_rs2 = 1'b1;
            end
            `CORE_OP_OP_IMM: begin
                payload.reg_write = 1'b1;
                payload.alu_src = 1'b1;
                payload.imm = imm_i;
                // only the shift form carries funct7
                payload.alu_op = alu_decode(funct3, instr_d[30] && funct3 == 3'b101);
            end
            `CORE_OP_LUI: begin
                payload.reg_write = 1'b1;
                payload.alu_src = 1'b1;
                payload.imm = imm_u;
                payload.alu_op = core_pkg::ALU_PASS_B;
                use_rs1 = 1'b0;
            end
            `CORE_OP_LOAD: begin
                payload.reg_write = 1'b1;
                payload.mem_read = 1'b1;
                payload.alu_src = 1'b1;
                payload.imm = imm_i;
                payload.result_src = core_pkg::RES_MEM;
            end
            `CORE_OP_STORE: begin
                payload.mem_write = 1'b1;
                payload.alu_src = 1'b1;
                payload.imm = imm_s;
                use_rs2 = 1'b1;
            end
            `CORE_OP_BRANCH: begin
                payload.branch = 1'b1;
                payload.branch_ne = funct3[0];
                payload.imm = imm_b;
                use_rs2 = 1'b1;
            end
            `CORE_OP_JAL: begin
                payload.reg_write = 1'b1;
                payload.jump = 1'b1;
                payload.imm = imm_j;
                payload.result_src = core_pkg::RES_PC4;
                use_rs1 = 1'b0;
            end
            default: known = 1'b0;
        endcase
        // unused source fields cleared so they raise no false hazards
        if (known) begin
            payload.rs1 = use_rs1 ? rs1 : 5'd0;
            payload.rs2 = use_rs2 ? rs2 : 5'd0;
            payload.rd1 = use_rs1 ? rd1 : '0;
            payload.rd2 = use_rs2 ? rd2 : '0;
            payload.rd = payload.reg_write ? instr_d[11:7] : 5'd0;
            payload.pc = pc_d;
            payload.pc_plus4 = pc_d + 32'd4;
        end
    end

endmodule

`default_nettype wire

//--- core/mem_writeback.sv
`default_nettype none

module mem_writeback (
    input wire core_pkg::exec_payload_t payload_m,
    input wire core_pkg::wb_payload_t payload_w,
    input wire core_pkg::word_t read_data,
    output logic data_re,
    output logic data_we,
    output core_pkg::word_t data_addr,
    output core_pkg::word_t din,
    output core_pkg::wb_payload_t payload_out,
    output core_pkg::reg_idx_t rd_w,
    output core_pkg::word_t result_w,
    output logic reg_write_w
);

    // request follows m_reg, which holds while the access waits
    assign data_re = payload_m.mem_read;
    assign data_we = payload_m.mem_write;
    assign data_addr = payload_m.alu_result;
    assign din = payload_m.write_data;

    assign payload_out.reg_write = payload_m.reg_write;
    assign payload_out.result_src = payload_m.result_src;
    assign payload_out.alu_result = payload_m.alu_result;
    assign payload_out.read_data = read_data;
    assign payload_out.rd = payload_m.rd;
    assign payload_out.pc_plus4 = payload_m.pc_plus4;

    assign rd_w = payload_w.rd;
    assign reg_write_w = payload_w.reg_write;

    always_comb begin
        case (payload_w.result_src)
            core_pkg::RES_MEM: result_w = payload_w.read_data;
            core_pkg::RES_PC4: result_w = payload_w.pc_plus4;
            default: result_w = payload_w.alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- core/pipeline_core.sv
`default_nettype none

`include "core_defs.svh"

module pipeline_core (
    input wire clk,
    input wire rst,
    input wire core_pkg::word_t instr,
    output core_pkg::word_t pc,
    output logic en_instr_mem,
    input wire core_pkg::word_t read_data,
    input wire cache_data_valid,
    output logic data_we,
    output logic data_re,
    output core_pkg::word_t data_addr,
    output core_pkg::word_t din
);

    core_pkg::word_t instr_d;
    core_pkg::word_t pc_d;

    core_pkg::dec_payload_t dec_d;
    core_pkg::dec_payload_t dec_hold;
    core_pkg::dec_payload_t e_in;
    core_pkg::dec_payload_t e_q;
    core_pkg::exec_payload_t exec_e;
    core_pkg::exec_payload_t m_q;
    core_pkg::wb_payload_t mem_m;
    core_pkg::wb_payload_t w_q;

    core_pkg::reg_idx_t rd_w;
    core_pkg::word_t result_w;
    logic reg_write_w;
    core_pkg::word_t fwd_m;
    core_pkg::word_t pc_target;
    logic pc_src;

    logic stall_f;
    logic stall_d;
    logic stall_e;
    logic stall_m;
    logic flush_d;
    logic flush_e;
    logic flush_w;
    core_pkg::fwd_sel_e fwd_a;
    core_pkg::fwd_sel_e fwd_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
        end else if (!stall_f) begin
            pc <= pc_src ? pc_target : pc + 32'd4;
        end
    end

    // fetch register
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            instr_d <= `CORE_NOP;
            pc_d <= '0;
        end else if (!stall_d) begin
            instr_d <= instr;
            pc_d <= pc;
        end
    end

    assign en_instr_mem = !stall_d;

    instr_decode i_instr_decode (
        .clk(clk),
        .rst(rst),
        .instr_d(instr_d),
        .pc_d(pc_d),
        .rd_w(rd_w),
        .result_w(result_w),
        .reg_write_w(reg_write_w),
        .payload(dec_d)
    );

    // writeback is bubbled during a memory wait, so a held execute
    // instruction keeps the value it was forwarded from there
    always_comb begin
        dec_hold = e_q;
        if (fwd_a == core_pkg::FWD_WB) begin
            dec_hold.rd1 = result_w;
        end
        if (fwd_b == core_pkg::FWD_WB) begin
            dec_hold.rd2 = result_w;
        end
    end

    assign e_in = stall_e ? dec_hold : dec_d;

    stage_reg #(.payload_t(core_pkg::dec_payload_t)) e_reg (
        .clk(clk),
        .rst(rst),
        .stall(1'b0),
        .flush(flush_e),
        .d(e_in),
        .q(e_q)
    );

    // jal in the memory stage forwards its link value
    assign fwd_m = (m_q.result_src == core_pkg::RES_PC4) ? m_q.pc_plus4 : m_q.alu_result;

    exec i_exec (
        .payload(e_q),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .alu_result_m(fwd_m),
        .result_w(result_w),
        .payload_out(exec_e),
        .pc_src(pc_src),
        .pc_target(pc_target)
    );

    stage_reg #(.payload_t(core_pkg::exec_payload_t)) m_reg (
        .clk(clk),
        .rst(rst),
        .stall(stall_m),
        .flush(1'b0),
        .d(exec_e),
        .q(m_q)
    );

    mem_writeback i_mem_writeback (
        .payload_m(m_q),
        .payload_w(w_q),
        .read_data(read_data),
        .data_re(data_re),
        .data_we(data_we),
        .data_addr(data_addr),
        .din(din),
        .payload_out(mem_m),
        .rd_w(rd_w),
        .result_w(result_w),
        .reg_write_w(reg_write_w)
    );

    stage_reg #(.payload_t(core_pkg::wb_payload_t)) w_reg (
        .clk(clk),
        .rst(rst),
        .stall(1'b0),
        .flush(flush_w),
        .d(mem_m),
        .q(w_q)
    );

    hazard_unit i_hazard_unit (
        .rs1_d(dec_d.rs1),
        .rs2_d(dec_d.rs2),
        .rs1_e(e_q.rs1),
        .rs2_e(e_q.rs2),
        .rd_e(e_q.rd),
        .rd_m(m_q.rd),
        .rd_w(rd_w),
        .mem_read_e(e_q.mem_read),
        .reg_write_m(m_q.reg_write),
        .reg_write_w(reg_write_w),
        .pc_src(pc_src),
        .mem_req_m(m_q.mem_read || m_q.mem_write),
        .cache_data_valid(cache_data_valid),
        .stall_f(stall_f),
        .stall_d(stall_d),
        .stall_e(stall_e),
        .stall_m(stall_m),
        .flush_d(flush_d),
        .flush_e(flush_e),
        .flush_w(flush_w),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/core_pkg.sv
verilog/stage_reg.sv
verilog/hazard_unit.sv
core/instr_decode.sv
core/exec.sv
core/mem_writeback.sv
core/pipeline_core.sv
testbench/pipeline_core_properties.sv
testbench/tb_pipeline_core.sv

//--- testbench/pipeline_core_properties.sv
`default_nettype none

module pipeline_core_properties (
    input wire clk,
    input wire rst,
    input wire core_pkg::word_t pc,
    input wire data_re,
    input wire data_we,
    input wire core_pkg::word_t data_addr,
    input wire core_pkg::word_t din,
    input wire cache_data_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    no_read_write_overlap: assert property (@(posedge clk) disable iff (rst)
        !(data_re && data_we))
        else $error("data_re and data_we are high together");

    // a waiting request holds until cache_data_valid
    request_held: assert property (@(posedge clk) disable iff (rst)
        ((data_re || data_we) && !cache_data_valid) |=>
            ($stable(data_addr) && $stable(din) && $stable(data_re) && $stable(data_we)))
        else $error("data request changed before cache_data_valid");

    idle_after_reset: assert property (@(posedge clk)
        rst |=> (!data_re && !data_we))
        else $error("memory request in the cycle after reset");

    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

`default_nettype wire

//--- testbench/program_input.hex
// one 32-bit hex word per entry: instruction count, instruction words,
// then store count and store address / store data pairs in program order
0000002b
// addi x1 / addi x2,x1 / sub x3,x2,x1 / sw x3 with no nops between
00500093 00708113 401101b3 10302023
// addi x4,-16 / add / and / or / xor / slt / sll / srl / sra, each stored
ff000213 002082b3 10502223 00527333
10602423 001263b3 10702623 00524433
10802823 001224b3 10902a23 00109533
10a02c23 001255b3 10b02e23 40125633
12c02023
// andi / ori / xori / slti, then four stores
0ff27693 7000e713 fff24793 0030a813
12d02223 12e02423 12f02623 13002823
// lui, store it, load it back, addi on the loaded value, store
123458b7 13102a23 13402903 00190993
13302c23
// taken beq over a store, bne not taken, jal x20 over two stores
00108463 1e102823 00109463 12202e23
00c00a6f 1e102a23 1e102c23 15402023
// jal x0,0 self-loop
0000006f
// expected stores
00000011
00000100 00000007
00000104 00000011
00000108 00000010
0000010c fffffff5
00000110 ffffffe1
00000114 00000001
00000118 000000a0
0000011c 07ffffff
00000120 ffffffff
00000124 000000f0
00000128 00000705
0000012c 0000000f
00000130 00000000
00000134 12345000
00000138 12345001
0000013c 0000000c
00000140 0000009c

//--- testbench/tb_pipeline_core.sv
`default_nettype none

`include "core_defs.svh"

module tb_pipeline_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int FILE_WORDS = 512;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 16;

    logic clk;
    logic rst;
    core_pkg::word_t instr;
    core_pkg::word_t pc;
    logic en_instr_mem;
    core_pkg::word_t read_data;
    logic cache_data_valid;
    logic data_we;
    logic data_re;
    core_pkg::word_t data_addr;
    core_pkg::word_t din;

    logic [31:0] file_words [0:FILE_WORDS-1];
    core_pkg::word_t imem [0:IMEM_WORDS-1];
    core_pkg::word_t dmem [0:DMEM_WORDS-1];
    core_pkg::word_t exp_addr [$];
    core_pkg::word_t exp_data [$];

    int instr_count;
    int store_count;
    int stores_seen;
    int watchdog_cycles;
    int wait_left;
    logic in_flight;
    logic withheld;
    core_pkg::word_t held_pc;
    integer seed = 32'he36a_bddd;

    bind pipeline_core pipeline_core_properties i_pipeline_core_properties (
        .clk(clk),
        .rst(rst),
        .pc(pc),
        .data_re(data_re),
        .data_we(data_we),
        .data_addr(data_addr),
        .din(din),
        .cache_data_valid(cache_data_valid)
    );

    pipeline_core i_pipeline_core (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .en_instr_mem(en_instr_mem),
        .read_data(read_data),
        .cache_data_valid(cache_data_valid),
        .data_we(data_we),
        .data_re(data_re),
        .data_addr(data_addr),
        .din(din)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // instruction memory answers in the same cycle
    assign instr = imem[pc[9:2]];

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_store_addr(input core_pkg::word_t actual,
                                    input core_pkg::word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: data_addr is %h, expected %h", actual, expected));
        end
    endtask

    task automatic check_store_data(input core_pkg::word_t actual,
                                    input core_pkg::word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: din is %h, expected %h", actual, expected));
        end
    endtask

    task automatic compare_pc(input core_pkg::word_t actual, input core_pkg::word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: pc is %h, expected %h", actual, expected));
        end
    endtask

    task automatic compare_en_instr_mem(input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: en_instr_mem is %h, expected %h",
                                actual, expected));
        end
    endtask

    task automatic load_program();
        int i;
        int pos;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = `CORE_NOP;
        end
        // each word tagged with its own byte address
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'h8000_0000 | (32'(i) << 2);
        end
        $readmemh("testbench/program_input.hex", file_words);
        instr_count = int'(file_words[0]);
        if (instr_count < 1 || instr_count > IMEM_WORDS) begin
            abort_run("instruction count in the program file is out of range");
        end
        for (i = 0; i < instr_count; i++) begin
            imem[i] = file_words[1 + i];
        end
        if (imem[instr_count-1][6:0] != `CORE_OP_JAL) begin
            abort_run("program does not end in a jal self-loop");
        end
        pos = 1 + instr_count;
        store_count = int'(file_words[pos]);
        if (store_count < 1 || pos + 2 * store_count >= FILE_WORDS) begin
            abort_run("store count in the program file is out of range");
        end
        for (i = 0; i < store_count; i++) begin
            exp_addr.push_back(file_words[pos + 1 + 2 * i]);
            exp_data.push_back(file_words[pos + 2 + 2 * i]);
        end
    endtask

    task automatic serve_request();
        int idx;
        idx = int'(data_addr[9:2]);
        if (data_we) begin
            if (stores_seen >= store_count) begin
                abort_run($sformatf("unexpected extra store to address %h", data_addr));
            end else begin
                check_store_addr(data_addr, exp_addr[stores_seen]);
                check_store_data(din, exp_data[stores_seen]);
                dmem[idx] = din;
                stores_seen++;
            end
        end else begin
            if (stores_seen == 0) begin
                abort_run("load request seen before the first store of the program");
            end
            read_data <= dmem[idx];
        end
        cache_data_valid <= 1'b1;
    endtask

    // data memory, 0 to 3 wait cycles per request
    always @(negedge clk) begin
        cache_data_valid <= 1'b0;
        // a withheld cycle must leave the pc where it was
        if (withheld) begin
            compare_pc(pc, held_pc);
        end
        withheld = 1'b0;
        if (rst) begin
            in_flight = 1'b0;
        end else if (data_re || data_we) begin
            if (!in_flight) begin
                in_flight = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                serve_request();
                in_flight = 1'b0;
            end else begin
                wait_left = wait_left - 1;
                withheld = 1'b1;
                held_pc = pc;
            end
        end
    end

    // fetch pauses while the access waits
    always @(posedge clk) begin
        if (withheld) begin
            compare_en_instr_mem(en_instr_mem, 1'b0);
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles with %0d of %0d stores seen",
                            watchdog_cycles, stores_seen, store_count));
    end

    initial begin
        rst = 1'b1;
        read_data = '0;
        cache_data_valid = 1'b0;
        in_flight = 1'b0;
        withheld = 1'b0;
        held_pc = '0;
        wait_left = 0;
        stores_seen = 0;
        load_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst <= 1'b0;
        compare_pc(pc, `CORE_RESET_PC);
        watchdog_cycles = 20 * instr_count + 8 * store_count;
        wait (stores_seen == store_count);
        // a repeated store would show up in these cycles
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input wire core_pkg::reg_idx_t rs1_d,
    input wire core_pkg::reg_idx_t rs2_d,
    input wire core_pkg::reg_idx_t rs1_e,
    input wire core_pkg::reg_idx_t rs2_e,
    input wire core_pkg::reg_idx_t rd_e,
    input wire core_pkg::reg_idx_t rd_m,
    input wire core_pkg::reg_idx_t rd_w,
    input wire mem_read_e,
    input wire reg_write_m,
    input wire reg_write_w,
    input wire pc_src,
    input wire mem_req_m,
    input wire cache_data_valid,
    output logic stall_f,
    output logic stall_d,
    output logic stall_e,
    output logic stall_m,
    output logic flush_d,
    output logic flush_e,
    output logic flush_w,
    output core_pkg::fwd_sel_e fwd_a,
    output core_pkg::fwd_sel_e fwd_b
);

    logic mem_wait;
    logic load_use;

    // memory stage wins over writeback, x0 never forwards
    function automatic core_pkg::fwd_sel_e pick_src(
        input core_pkg::reg_idx_t rs,
        input core_pkg::reg_idx_t rd_mem,
        input logic wr_mem,
        input core_pkg::reg_idx_t rd_wb,
        input logic wr_wb
    );
        core_pkg::fwd_sel_e sel;
        sel = core_pkg::FWD_RF;
        if (rs != 5'd0 && wr_mem && rd_mem == rs) begin
            sel = core_pkg::FWD_MEM;
        end else if (rs != 5'd0 && wr_wb && rd_wb == rs) begin
            sel = core_pkg::FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a = pick_src(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
    assign fwd_b = pick_src(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

    assign mem_wait = mem_req_m && !cache_data_valid;
    assign load_use = mem_read_e && (rd_e != 5'd0) && (rd_e == rs1_d || rd_e == rs2_d);

    assign stall_f = mem_wait || load_use;
    assign stall_d = mem_wait || load_use;
    assign stall_e = mem_wait;
    assign stall_m = mem_wait;

    // flushes wait until the memory stage lets go
    assign flush_d = pc_src && !mem_wait;
    assign flush_e = (pc_src || load_use) && !mem_wait;
    assign flush_w = mem_wait;

endmodule

`default_nettype wire

//--- verilog/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire flush,
    input wire payload_t d,
    output payload_t q
);

    // a cleared payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire
